/* project.f */
verilog/fetch_pkg.sv
verilog/fetch_cmd_decode.sv
verilog/fetch_pc_gen.sv
verilog/fetch_imem.sv
verilog/fetch_ctrl.sv
verilog/fetch_top.sv
test/tb_fetch_top.sv

/* test/tb_fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top;

  localparam int CLK_PERIOD     = 8;
  localparam int N_ROWS         = 8;
  localparam int IDLE_CYCLES    = 8;
  localparam int CYCLES_PER_MSG = 200;

  logic                                  clk_i;
  logic                                  reset_i;
  logic                                  fe_cmd_v_i;
  fetch_pkg::fe_opcode_e                 fe_cmd_opcode_i;
  logic [fetch_pkg::VADDR_WIDTH-1:0]     fe_cmd_vaddr_i;
  logic                                  fe_cmd_yumi_o;
  logic                                  fe_queue_v_o;
  fetch_pkg::fe_msg_type_e               fe_queue_type_o;
  logic [fetch_pkg::VADDR_WIDTH-1:0]     fe_queue_pc_o;
  logic [fetch_pkg::INSTR_WIDTH-1:0]     fe_queue_instr_o;
  fetch_pkg::fe_exc_code_e               fe_queue_exc_o;
  logic                                  fe_queue_ready_i;
  logic                                  imem_w_v_i;
  logic [fetch_pkg::IMEM_ADDR_WIDTH-1:0] imem_w_addr_i;
  logic [fetch_pkg::INSTR_WIDTH-1:0]     imem_w_data_i;

  // Stimulus table of command, start address, message count and back-pressure
  fetch_pkg::fe_opcode_e row_op [N_ROWS];
  logic [31:0]           row_addr [N_ROWS];
  int                    row_count [N_ROWS];
  logic                  row_bp [N_ROWS];

  logic [31:0] exp_type_q [$];
  logic [31:0] exp_pc_q [$];
  logic [31:0] exp_instr_q [$];
  logic [31:0] exp_exc_q [$];

  integer seed;
  logic   bp_en;
  logic   last_exc;
  int     total_msgs;
  logic   table_loaded;

  fetch_top u_fetch_top
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_opcode_i  (fe_cmd_opcode_i),
    .fe_cmd_vaddr_i   (fe_cmd_vaddr_i),
    .fe_cmd_yumi_o    (fe_cmd_yumi_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_type_o  (fe_queue_type_o),
    .fe_queue_pc_o    (fe_queue_pc_o),
    .fe_queue_instr_o (fe_queue_instr_o),
    .fe_queue_exc_o   (fe_queue_exc_o),
    .fe_queue_ready_i (fe_queue_ready_i),
    .imem_w_v_i       (imem_w_v_i),
    .imem_w_addr_i    (imem_w_addr_i),
    .imem_w_data_i    (imem_w_data_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] word_pattern(input int idx);
    return 32'(idx) * 32'h0104_0a13 + 32'h0000_0093;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string what);
    $display("ERROR: %s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic set_row(input int idx, input fetch_pkg::fe_opcode_e op,
                         input logic [31:0] addr, input int count, input logic bp);
    row_op[idx]    = op;
    row_addr[idx]  = addr;
    row_count[idx] = count;
    row_bp[idx]    = bp;
    total_msgs     = total_msgs + count;
  endtask

  // Walk the PC from the start address until the count or the first fault
  task automatic predict_row(input logic [31:0] start, input int count);
    logic [31:0] pc;
    int          produced;
    pc       = start;
    produced = 0;
    last_exc = 1'b0;
    while (produced < count && !last_exc)
    begin
      exp_pc_q.push_back(pc);
      if (pc[1:0] != 2'b00)
      begin
        exp_type_q.push_back(32'(fetch_pkg::e_fe_exception));
        exp_instr_q.push_back(32'h0);
        exp_exc_q.push_back(32'(fetch_pkg::e_instr_misaligned));
        last_exc = 1'b1;
      end
      else if ((pc >> 2) >= fetch_pkg::IMEM_DEPTH)
      begin
        exp_type_q.push_back(32'(fetch_pkg::e_fe_exception));
        exp_instr_q.push_back(32'h0);
        exp_exc_q.push_back(32'(fetch_pkg::e_instr_access_fault));
        last_exc = 1'b1;
      end
      else
      begin
        exp_type_q.push_back(32'(fetch_pkg::e_fe_fetch));
        exp_instr_q.push_back(word_pattern(int'(pc >> 2)));
        exp_exc_q.push_back(32'h0);
      end
      pc       = pc + 32'd4;
      produced = produced + 1;
    end
    if (produced != count)
      fail_run("stimulus row message count disagrees with the fetch model");
  endtask

  // Drive just after the rising edge and check at the falling edge
  task automatic drive_cycle(input logic cmd_v, input fetch_pkg::fe_opcode_e op,
                             input logic [31:0] addr);
    logic [31:0] rnd;
    @(posedge clk_i);
    #1;
    imem_w_v_i      = 1'b0;
    fe_cmd_v_i      = cmd_v;
    fe_cmd_opcode_i = op;
    fe_cmd_vaddr_i  = addr;
    rnd             = $random(seed);
    fe_queue_ready_i = bp_en ? (rnd[1:0] != 2'b00) : 1'b1;
    @(negedge clk_i);
    check_value("fe_cmd_yumi_o", 32'(fe_cmd_yumi_o), 32'(cmd_v));
    if (fe_queue_v_o)
    begin
      if (exp_pc_q.size() == 0)
        fail_run("queue message arrived while none was expected");
      else
      begin
        check_value("fe_queue_pc_o", fe_queue_pc_o, exp_pc_q.pop_front());
        check_value("fe_queue_type_o", 32'(fe_queue_type_o), exp_type_q.pop_front());
        check_value("fe_queue_instr_o", fe_queue_instr_o, exp_instr_q.pop_front());
        check_value("fe_queue_exc_o", 32'(fe_queue_exc_o), exp_exc_q.pop_front());
      end
    end
  endtask

  initial
  begin
    wait (table_loaded);
    #(total_msgs * CYCLES_PER_MSG * CLK_PERIOD);
    fail_run("watchdog expired before all stimulus rows finished");
  end

  initial
  begin
    int cycles;
    seed             = 52770;
    bp_en            = 1'b0;
    last_exc         = 1'b0;
    total_msgs       = 0;
    table_loaded     = 1'b0;
    reset_i          = 1'b1;
    fe_cmd_v_i       = 1'b0;
    fe_cmd_opcode_i  = fetch_pkg::e_op_state_reset;
    fe_cmd_vaddr_i   = '0;
    fe_queue_ready_i = 1'b1;
    imem_w_v_i       = 1'b0;
    imem_w_addr_i    = '0;
    imem_w_data_i    = '0;

    set_row(0, fetch_pkg::e_op_pc_redirect, 32'h0000_0000, 8, 1'b0);
    set_row(1, fetch_pkg::e_op_state_reset, 32'h0000_0000, 8, 1'b0);
    set_row(2, fetch_pkg::e_op_pc_redirect, 32'h0000_0040, 12, 1'b1);
    set_row(3, fetch_pkg::e_op_pc_redirect, 32'h0000_00f0, 5, 1'b0);
    set_row(4, fetch_pkg::e_op_pc_redirect, 32'h0000_00e8, 7, 1'b1);
    set_row(5, fetch_pkg::e_op_pc_redirect, 32'h0000_0022, 1, 1'b0);
    set_row(6, fetch_pkg::e_op_state_reset, 32'h0000_0080, 6, 1'b1);
    set_row(7, fetch_pkg::e_op_pc_redirect, 32'h0000_0010, 4, 1'b0);
    table_loaded = 1'b1;

    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Memory is loaded while the front end sits in wait
    for (int i = 0; i < fetch_pkg::IMEM_DEPTH; i++)
    begin
      @(posedge clk_i);
      #1;
      imem_w_v_i    = 1'b1;
      imem_w_addr_i = fetch_pkg::IMEM_ADDR_WIDTH'(i);
      imem_w_data_i = word_pattern(i);
      @(negedge clk_i);
      check_value("fe_queue_v_o", 32'(fe_queue_v_o), 32'h0);
      check_value("fe_cmd_yumi_o", 32'(fe_cmd_yumi_o), 32'h0);
    end
    repeat (4) drive_cycle(1'b0, fetch_pkg::e_op_state_reset, '0);

    for (int r = 0; r < N_ROWS; r++)
    begin
      bp_en = row_bp[r];
      predict_row(row_addr[r], row_count[r]);
      drive_cycle(1'b1, row_op[r], row_addr[r]);
      cycles = 0;
      while (exp_pc_q.size() != 0)
      begin
        if (cycles > CYCLES_PER_MSG * row_count[r])
          fail_run("timed out waiting for queue messages");
        else
        begin
          drive_cycle(1'b0, fetch_pkg::e_op_state_reset, '0);
          cycles = cycles + 1;
        end
      end
      // Park a running front end so nothing may arrive before the next row
      if (!last_exc)
        drive_cycle(1'b1, fetch_pkg::e_op_wait, '0);
      repeat (IDLE_CYCLES) drive_cycle(1'b0, fetch_pkg::e_op_state_reset, '0);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/fetch_cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_cmd_decode
(
  input  wire                                 clk_i,
  input  wire                                 reset_i,
  input  wire                                 fe_cmd_v_i,
  input  fetch_pkg::fe_opcode_e               fe_cmd_opcode_i,
  input  wire [fetch_pkg::VADDR_WIDTH-1:0]    fe_cmd_vaddr_i,
  input  wire                                 is_run_i,
  input  wire [fetch_pkg::VADDR_WIDTH-1:0]    fetch_pc_i,
  output logic                                cmd_v_o,
  output logic                                cmd_immediate_o,
  output logic                                cmd_wait_o,
  output logic [fetch_pkg::VADDR_WIDTH-1:0]   resume_pc_o
);

  logic [fetch_pkg::VADDR_WIDTH-1:0] resume_n;
  logic [fetch_pkg::VADDR_WIDTH-1:0] resume_r;
  logic                              resume_en;

  assign cmd_v_o         = fe_cmd_v_i;
  assign cmd_immediate_o = fe_cmd_v_i & (fe_cmd_opcode_i == fetch_pkg::e_op_pc_redirect);
  assign cmd_wait_o      = fe_cmd_v_i & (fe_cmd_opcode_i == fetch_pkg::e_op_wait);

  // A command sets the restart point, otherwise track the IF2 PC while running
  assign resume_en = fe_cmd_v_i | is_run_i;
  assign resume_n  = fe_cmd_v_i ? fe_cmd_vaddr_i : fetch_pc_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resume_r <= '0;
    end
    else if (resume_en)
    begin
      resume_r <= resume_n;
    end
  end

  assign resume_pc_o = resume_r;

  // Back end only issues the three supported opcodes
  a_known_opcode: assert property (
    @(posedge clk_i) disable iff (reset_i)
    fe_cmd_v_i |-> fe_cmd_opcode_i inside {fetch_pkg::e_op_state_reset,
                                           fetch_pkg::e_op_pc_redirect,
                                           fetch_pkg::e_op_wait}
  );

endmodule

`default_nettype wire

/* verilog/fetch_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl
(
  input  wire                                 clk_i,
  input  wire                                 reset_i,
  input  wire                                 cmd_v_i,
  input  wire                                 cmd_immediate_i,
  input  wire                                 cmd_wait_i,
  input  wire [fetch_pkg::VADDR_WIDTH-1:0]    if2_pc_i,
  input  wire [fetch_pkg::INSTR_WIDTH-1:0]    rdata_i,
  input  wire                                 access_fault_i,
  input  wire                                 misaligned_fault_i,
  input  wire                                 fe_queue_ready_i,
  output logic                                next_pc_yumi_o,
  output logic                                redirect_v_o,
  output logic                                is_run_o,
  output logic                                fe_cmd_yumi_o,
  output logic                                fe_queue_v_o,
  output fetch_pkg::fe_msg_type_e             fe_queue_type_o,
  output logic [fetch_pkg::VADDR_WIDTH-1:0]   fe_queue_pc_o,
  output logic [fetch_pkg::INSTR_WIDTH-1:0]   fe_queue_instr_o,
  output fetch_pkg::fe_exc_code_e             fe_queue_exc_o
);

  fetch_pkg::fe_state_e state_r;
  fetch_pkg::fe_state_e state_n;

  logic is_wait;
  logic is_stall;
  logic cmd_complex;

  logic v_if1_r;
  logic v_if2_r;
  logic v_if1_n;
  logic v_if2_n;
  logic seq_r;

  logic fault_v;
  logic fe_exception_v;
  logic fetch_fail_v;
  logic exception_sent;
  logic poison_if1;
  logic stall;
  logic unstall;

  assign is_wait  = (state_r == fetch_pkg::e_wait);
  assign is_run_o = (state_r == fetch_pkg::e_run);
  assign is_stall = (state_r == fetch_pkg::e_stall);

  // State reset is the only command that needs the stall detour
  assign cmd_complex = cmd_v_i & ~cmd_immediate_i & ~cmd_wait_i;

  assign fault_v        = access_fault_i | misaligned_fault_i;
  assign fe_exception_v = v_if2_r & fault_v;
  assign fe_queue_v_o   = fe_queue_ready_i & v_if2_r & ~cmd_v_i;
  assign exception_sent = fe_queue_v_o & fault_v;
  assign fetch_fail_v   = v_if2_r & ~fe_queue_v_o;

  assign poison_if1 = fetch_fail_v | fe_exception_v | cmd_v_i;
  assign stall      = fetch_fail_v | cmd_v_i;
  assign unstall    = fe_queue_ready_i & ~cmd_v_i;

  assign fe_cmd_yumi_o = cmd_v_i & ~reset_i;

  always_comb
  begin
    case (state_r)
      fetch_pkg::e_wait:
        state_n = cmd_wait_i      ? fetch_pkg::e_wait :
                  cmd_immediate_i ? fetch_pkg::e_run :
                  cmd_v_i         ? fetch_pkg::e_stall : fetch_pkg::e_wait;
      fetch_pkg::e_stall:
        state_n = cmd_wait_i ? fetch_pkg::e_wait :
                  unstall    ? fetch_pkg::e_run : fetch_pkg::e_stall;
      // A redirect keeps running and the new PC goes out on the next issue
      fetch_pkg::e_run:
        state_n = cmd_wait_i             ? fetch_pkg::e_wait :
                  cmd_immediate_i        ? fetch_pkg::e_run :
                  (stall | cmd_complex)  ? fetch_pkg::e_stall :
                  exception_sent         ? fetch_pkg::e_wait : fetch_pkg::e_run;
      default:
        state_n = fetch_pkg::e_wait;
    endcase
  end

  assign v_if1_n = (state_n == fetch_pkg::e_run);
  assign v_if2_n = v_if1_r & ~poison_if1;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= fetch_pkg::e_wait;
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
      seq_r   <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      v_if1_r <= v_if1_n;
      v_if2_r <= v_if2_n;
      seq_r   <= is_run_o & ~cmd_v_i;
    end
  end

  // First issue after a command or a stall restarts from the resume PC
  assign next_pc_yumi_o = v_if1_r;
  assign redirect_v_o   = v_if1_r & ~seq_r;

  always_comb
  begin
    fe_queue_pc_o = if2_pc_i;
    if (fault_v)
    begin
      fe_queue_type_o  = fetch_pkg::e_fe_exception;
      fe_queue_instr_o = '0;
      fe_queue_exc_o   = misaligned_fault_i ? fetch_pkg::e_instr_misaligned
                                            : fetch_pkg::e_instr_access_fault;
    end
    else
    begin
      fe_queue_type_o  = fetch_pkg::e_fe_fetch;
      fe_queue_instr_o = rdata_i;
      fe_queue_exc_o   = fetch_pkg::e_instr_access_fault;
    end
  end

  a_v_needs_ready: assert property (
    @(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i
  );

  // An exception parks the front end until the next command
  a_exception_parks: assert property (
    @(posedge clk_i) disable iff (reset_i)
    exception_sent |=> (is_wait && !v_if2_r)
  );

  // Nothing is left in flight while stalled
  a_stall_empty: assert property (
    @(posedge clk_i) disable iff (reset_i)
    is_stall |-> !v_if2_r
  );

endmodule

`default_nettype wire

/* verilog/fetch_imem.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_imem
(
  input  wire                                     clk_i,
  input  wire                                     reset_i,
  input  wire                                     w_v_i,
  input  wire [fetch_pkg::IMEM_ADDR_WIDTH-1:0]    w_addr_i,
  input  wire [fetch_pkg::INSTR_WIDTH-1:0]        w_data_i,
  input  wire                                     r_v_i,
  input  wire [fetch_pkg::VADDR_WIDTH-1:0]        r_pc_i,
  output logic [fetch_pkg::INSTR_WIDTH-1:0]       rdata_o,
  output logic [fetch_pkg::VADDR_WIDTH-1:0]       pc_o,
  output logic                                    access_fault_o,
  output logic                                    misaligned_fault_o
);

  logic [fetch_pkg::INSTR_WIDTH-1:0] mem [fetch_pkg::IMEM_DEPTH];

  logic [fetch_pkg::IMEM_ADDR_WIDTH-1:0] r_index;
  logic [fetch_pkg::VADDR_WIDTH-1:0]     r_word;
  logic                                  access_fault_n;
  logic                                  misaligned_n;

  logic [fetch_pkg::INSTR_WIDTH-1:0]     rdata_r;
  logic [fetch_pkg::VADDR_WIDTH-1:0]     pc_r;
  logic                                  access_fault_r;
  logic                                  misaligned_r;

  assign r_word  = r_pc_i >> 2;
  assign r_index = r_pc_i[fetch_pkg::IMEM_ADDR_WIDTH+1:2];

  assign access_fault_n = (r_word >= fetch_pkg::VADDR_WIDTH'(fetch_pkg::IMEM_DEPTH));
  assign misaligned_n   = (r_pc_i[1:0] != 2'b00);

  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
    begin
      mem[w_addr_i] <= w_data_i;
    end
  end

  // Read stage output lines up with IF2
  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
    begin
      rdata_r        <= mem[r_index];
      pc_r           <= r_pc_i;
      access_fault_r <= access_fault_n;
      misaligned_r   <= misaligned_n;
    end
  end

  assign rdata_o            = rdata_r;
  assign pc_o               = pc_r;
  assign access_fault_o     = access_fault_r;
  assign misaligned_fault_o = misaligned_r;

  // Loading happens only while the controller is parked
  a_no_write_on_read: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(w_v_i && r_v_i)
  );

endmodule

`default_nettype wire

/* verilog/fetch_pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen
(
  input  wire                                 clk_i,
  input  wire                                 reset_i,
  input  wire                                 redirect_v_i,
  input  wire [fetch_pkg::VADDR_WIDTH-1:0]    redirect_pc_i,
  input  wire                                 next_pc_yumi_i,
  output logic [fetch_pkg::VADDR_WIDTH-1:0]   next_pc_o
);

  localparam logic [fetch_pkg::VADDR_WIDTH-1:0] INSTR_BYTES = fetch_pkg::VADDR_WIDTH'(4);

  logic [fetch_pkg::VADDR_WIDTH-1:0] pc_r;
  logic [fetch_pkg::VADDR_WIDTH-1:0] pc_sel;

  // Redirect target goes out in the same cycle it is requested
  assign pc_sel = redirect_v_i ? redirect_pc_i : pc_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r <= '0;
    end
    else if (next_pc_yumi_i)
    begin
      pc_r <= pc_sel + INSTR_BYTES;
    end
  end

  assign next_pc_o = pc_sel;

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int VADDR_WIDTH = 32;
  localparam int INSTR_WIDTH = 32;

  // Word count of the local instruction memory
  localparam int IMEM_DEPTH = 64;
  localparam int IMEM_ADDR_WIDTH = 6;

  typedef enum logic [1:0]
  {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_wait        = 2'd2
  } fe_opcode_e;

  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  // Access fault doubles as the all-zero code on fetch messages
  typedef enum logic
  {
    e_instr_access_fault = 1'b0,
    e_instr_misaligned   = 1'b1
  } fe_exc_code_e;

endpackage

`default_nettype wire

/* verilog/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top
(
  input  wire                                     clk_i,
  input  wire                                     reset_i,

  input  wire                                     fe_cmd_v_i,
  input  fetch_pkg::fe_opcode_e                   fe_cmd_opcode_i,
  input  wire [fetch_pkg::VADDR_WIDTH-1:0]        fe_cmd_vaddr_i,
  output logic                                    fe_cmd_yumi_o,

  output logic                                    fe_queue_v_o,
  output fetch_pkg::fe_msg_type_e                 fe_queue_type_o,
  output logic [fetch_pkg::VADDR_WIDTH-1:0]       fe_queue_pc_o,
  output logic [fetch_pkg::INSTR_WIDTH-1:0]       fe_queue_instr_o,
  output fetch_pkg::fe_exc_code_e                 fe_queue_exc_o,
  input  wire                                     fe_queue_ready_i,

  input  wire                                     imem_w_v_i,
  input  wire [fetch_pkg::IMEM_ADDR_WIDTH-1:0]    imem_w_addr_i,
  input  wire [fetch_pkg::INSTR_WIDTH-1:0]        imem_w_data_i
);

  logic                              cmd_v;
  logic                              cmd_immediate;
  logic                              cmd_wait;
  logic [fetch_pkg::VADDR_WIDTH-1:0] resume_pc;
  logic                              is_run;
  logic                              next_pc_yumi;
  logic                              redirect_v;
  logic [fetch_pkg::VADDR_WIDTH-1:0] next_pc;
  logic [fetch_pkg::INSTR_WIDTH-1:0] rdata;
  logic [fetch_pkg::VADDR_WIDTH-1:0] fetch_pc;
  logic                              access_fault;
  logic                              misaligned;

  fetch_cmd_decode u_cmd_decode
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fe_cmd_v_i      (fe_cmd_v_i),
    .fe_cmd_opcode_i (fe_cmd_opcode_i),
    .fe_cmd_vaddr_i  (fe_cmd_vaddr_i),
    .is_run_i        (is_run),
    .fetch_pc_i      (fetch_pc),
    .cmd_v_o         (cmd_v),
    .cmd_immediate_o (cmd_immediate),
    .cmd_wait_o      (cmd_wait),
    .resume_pc_o     (resume_pc)
  );

  fetch_pc_gen u_pc_gen
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .redirect_v_i   (redirect_v),
    .redirect_pc_i  (resume_pc),
    .next_pc_yumi_i (next_pc_yumi),
    .next_pc_o      (next_pc)
  );

  fetch_imem u_imem
  (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .w_v_i              (imem_w_v_i),
    .w_addr_i           (imem_w_addr_i),
    .w_data_i           (imem_w_data_i),
    .r_v_i              (next_pc_yumi),
    .r_pc_i             (next_pc),
    .rdata_o            (rdata),
    .pc_o               (fetch_pc),
    .access_fault_o     (access_fault),
    .misaligned_fault_o (misaligned)
  );

  fetch_ctrl u_ctrl
  (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .cmd_v_i            (cmd_v),
    .cmd_immediate_i    (cmd_immediate),
    .cmd_wait_i         (cmd_wait),
    .if2_pc_i           (fetch_pc),
    .rdata_i            (rdata),
    .access_fault_i     (access_fault),
    .misaligned_fault_i (misaligned),
    .fe_queue_ready_i   (fe_queue_ready_i),
    .next_pc_yumi_o     (next_pc_yumi),
    .redirect_v_o       (redirect_v),
    .is_run_o           (is_run),
    .fe_cmd_yumi_o      (fe_cmd_yumi_o),
    .fe_queue_v_o       (fe_queue_v_o),
    .fe_queue_type_o    (fe_queue_type_o),
    .fe_queue_pc_o      (fe_queue_pc_o),
    .fe_queue_instr_o   (fe_queue_instr_o),
    .fe_queue_exc_o     (fe_queue_exc_o)
  );

endmodule

`default_nettype wire
